// ==== logic/mesh_pkg.sv ====
package mesh_pkg;

    // One flit on every link.
    typedef logic [31:0] flit_t;

    // Node address with x in the upper byte and y in the lower byte.
    typedef logic [15:0] node_addr_t;

    localparam int N_PORTS = 5;

    // Router port numbering, also used as the index of every per-port array.
    typedef enum logic [2:0] {
        PORT_EAST  = 3'd0,
        PORT_WEST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_SOUTH = 3'd3,
        PORT_LOCAL = 3'd4
    } port_e;

    // Header flit layout.
    // Destination sits in the low half, source in the high half.
    localparam int HDR_DEST_LSB = 0;
    localparam int HDR_SRC_LSB  = 16;

    // Output allocation state.
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

// ==== logic/input_buffer.sv ====
`timescale 1ns/1ps

module input_buffer #(
    parameter int BUF_DEPTH = 4,
    parameter int ROUTER_X  = 0,
    parameter int ROUTER_Y  = 0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  logic            rx_i,
    input  logic            eop_i,
    input  mesh_pkg::flit_t data_i,
    output logic            credit_o,

    output logic            req_o,
    output mesh_pkg::port_e route_o,
    output logic            head_eop_o,
    output mesh_pkg::flit_t head_data_o,
    input  logic            pop_i
);

    localparam int         PTR_W = $clog2(BUF_DEPTH);
    localparam logic [7:0] MY_X  = 8'(ROUTER_X);
    localparam logic [7:0] MY_Y  = 8'(ROUTER_Y);

    mesh_pkg::flit_t      data_mem [BUF_DEPTH];
    logic                 eop_mem  [BUF_DEPTH];

    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [PTR_W:0]       count_q;
    logic                 full;
    logic                 push;
    logic                 at_header_q;

    mesh_pkg::node_addr_t dest;
    mesh_pkg::port_e      head_route;
    mesh_pkg::port_e      route_q;

    assign full     = (count_q == (PTR_W + 1)'(BUF_DEPTH));
    assign credit_o = !full;
    assign push     = rx_i && !full;
    assign req_o    = (count_q != '0);

    assign head_data_o = data_mem[rd_ptr_q];
    assign head_eop_o  = eop_mem[rd_ptr_q];

    // XY decision on the flit at the head.
    // Only meaningful while that flit is a header.
    assign dest = head_data_o[mesh_pkg::HDR_DEST_LSB +: $bits(mesh_pkg::node_addr_t)];

    always_comb begin
        if (dest[15:8] > MY_X) begin
            head_route = mesh_pkg::PORT_EAST;
        end else if (dest[15:8] < MY_X) begin
            head_route = mesh_pkg::PORT_WEST;
        end else if (dest[7:0] > MY_Y) begin
            head_route = mesh_pkg::PORT_NORTH;
        end else if (dest[7:0] < MY_Y) begin
            head_route = mesh_pkg::PORT_SOUTH;
        end else begin
            head_route = mesh_pkg::PORT_LOCAL;
        end
    end

    // Body flits keep the route taken by their header.
    assign route_o = at_header_q ? head_route : route_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            at_header_q <= 1'b1;
            route_q     <= mesh_pkg::PORT_LOCAL;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q    <= rd_ptr_q + 1'b1;
                at_header_q <= head_eop_o;
            end
            if (pop_i && at_header_q) begin
                route_q <= head_route;
            end
            case ({push, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= data_i;
            eop_mem[wr_ptr_q]  <= eop_i;
        end
    end

    // A flit offered to a full buffer is not taken, so it stays on the link.
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (full && rx_i) |=> (rx_i && $stable(data_i) && $stable(eop_i))
    );

endmodule

// ==== logic/output_arbiter.sv ====
`timescale 1ns/1ps

module output_arbiter (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    input  logic [mesh_pkg::N_PORTS-1:0] req_i,
    output logic [mesh_pkg::N_PORTS-1:0] grant_o,
    input  logic                         xfer_eop_i
);

    localparam int NP = mesh_pkg::N_PORTS;

    mesh_pkg::arb_state_e state_q;
    mesh_pkg::port_e      last_q;
    mesh_pkg::port_e      next_port;
    logic                 found;

    // Search starts just after the last winner.
    always_comb begin
        int idx;
        next_port = last_q;
        found     = 1'b0;
        for (int i = 1; i <= NP; i++) begin
            idx = (int'(last_q) + i) % NP;
            if (!found && req_i[idx]) begin
                next_port = mesh_pkg::port_e'(idx);
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= mesh_pkg::ARB_IDLE;
            grant_o <= '0;
            last_q  <= mesh_pkg::PORT_LOCAL;
        end else begin
            case (state_q)
                mesh_pkg::ARB_IDLE: begin
                    if (found) begin
                        grant_o            <= '0;
                        grant_o[next_port] <= 1'b1;
                        last_q             <= next_port;
                        state_q            <= mesh_pkg::ARB_BUSY;
                    end
                end
                mesh_pkg::ARB_BUSY: begin
                    // Held for the whole packet.
                    if (xfer_eop_i) begin
                        grant_o <= '0;
                        state_q <= mesh_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    grant_o <= '0;
                    state_q <= mesh_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // A packet can only end on this output while exactly one input holds it.
    a_grant_onehot0: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        xfer_eop_i |-> (state_q == mesh_pkg::ARB_BUSY && $onehot(grant_o))
    );

endmodule

// ==== logic/hermes_router.sv ====
`timescale 1ns/1ps

module hermes_router #(
    parameter int ROUTER_X  = 0,
    parameter int ROUTER_Y  = 0,
    parameter int BUF_DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    input  logic [mesh_pkg::N_PORTS-1:0] rx_i,
    input  logic [mesh_pkg::N_PORTS-1:0] eop_i,
    input  mesh_pkg::flit_t              data_i   [mesh_pkg::N_PORTS],
    output logic [mesh_pkg::N_PORTS-1:0] credit_o,

    output logic [mesh_pkg::N_PORTS-1:0] tx_o,
    output logic [mesh_pkg::N_PORTS-1:0] eop_o,
    output mesh_pkg::flit_t              data_o   [mesh_pkg::N_PORTS],
    input  logic [mesh_pkg::N_PORTS-1:0] credit_i
);

    localparam int NP = mesh_pkg::N_PORTS;

    // Input side.
    logic [NP-1:0]   buf_req;
    mesh_pkg::port_e buf_route     [NP];
    logic [NP-1:0]   buf_head_eop;
    mesh_pkg::flit_t buf_head_data [NP];
    logic [NP-1:0]   buf_pop;

    // Output side, indexed [output][input].
    logic [NP-1:0]   arb_req   [NP];
    logic [NP-1:0]   arb_grant [NP];
    logic [NP-1:0]   xfer_eop;

    for (genvar i = 0; i < NP; i++) begin : gen_in
        input_buffer #(
            .BUF_DEPTH (BUF_DEPTH),
            .ROUTER_X  (ROUTER_X ),
            .ROUTER_Y  (ROUTER_Y )
        ) u_buf (
            .clk_i       (clk_i           ),
            .rst_n_i     (rst_n_i         ),
            .rx_i        (rx_i[i]         ),
            .eop_i       (eop_i[i]        ),
            .data_i      (data_i[i]       ),
            .credit_o    (credit_o[i]     ),
            .req_o       (buf_req[i]      ),
            .route_o     (buf_route[i]    ),
            .head_eop_o  (buf_head_eop[i] ),
            .head_data_o (buf_head_data[i]),
            .pop_i       (buf_pop[i]      )
        );
    end

    for (genvar o = 0; o < NP; o++) begin : gen_out
        output_arbiter u_arb (
            .clk_i      (clk_i       ),
            .rst_n_i    (rst_n_i     ),
            .req_i      (arb_req[o]  ),
            .grant_o    (arb_grant[o]),
            .xfer_eop_i (xfer_eop[o] )
        );
    end

    // Each input requests only the output its head packet is routed to.
    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                arb_req[o][i] = buf_req[i] && (buf_route[i] == mesh_pkg::port_e'(o));
            end
        end
    end

    // Crossbar.
    always_comb begin
        for (int o = 0; o < NP; o++) begin
            tx_o[o]   = 1'b0;
            eop_o[o]  = 1'b0;
            data_o[o] = '0;
            for (int i = 0; i < NP; i++) begin
                if (arb_grant[o][i]) begin
                    tx_o[o]   = buf_req[i];
                    eop_o[o]  = buf_req[i] && buf_head_eop[i];
                    data_o[o] = buf_head_data[i];
                end
            end
            // Last flit of the packet leaves, so the output is released.
            xfer_eop[o] = tx_o[o] && credit_i[o] && eop_o[o];
        end
    end

    // A flit is popped on the edge where its output moves it downstream.
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            buf_pop[i] = 1'b0;
            for (int o = 0; o < NP; o++) begin
                if (arb_grant[o][i] && buf_req[i] && credit_i[o]) begin
                    buf_pop[i] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/noc_mesh.sv ====
`timescale 1ns/1ps

module noc_mesh #(
    parameter int N_X       = 2,
    parameter int N_Y       = 2,
    parameter int BUF_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic [N_X*N_Y-1:0]   local_rx_i,
    input  logic [N_X*N_Y-1:0]   local_eop_i,
    input  mesh_pkg::flit_t      local_data_i   [N_X*N_Y],
    output logic [N_X*N_Y-1:0]   local_credit_o,

    output logic [N_X*N_Y-1:0]   local_tx_o,
    output logic [N_X*N_Y-1:0]   local_eop_o,
    output mesh_pkg::flit_t      local_data_o   [N_X*N_Y],
    input  logic [N_X*N_Y-1:0]   local_credit_i
);

    localparam int N_NODES = N_X * N_Y;
    localparam int NP      = mesh_pkg::N_PORTS;

    // Router receive side.
    logic [NP-1:0]   rx        [N_NODES];
    logic [NP-1:0]   eop_rx    [N_NODES];
    logic [NP-1:0]   credit_rx [N_NODES];
    mesh_pkg::flit_t data_rx   [N_NODES][NP];

    // Router transmit side.
    logic [NP-1:0]   tx        [N_NODES];
    logic [NP-1:0]   eop_tx    [N_NODES];
    logic [NP-1:0]   credit_tx [N_NODES];
    mesh_pkg::flit_t data_tx   [N_NODES][NP];

    for (genvar gy = 0; gy < N_Y; gy++) begin : gen_y
        for (genvar gx = 0; gx < N_X; gx++) begin : gen_x
            localparam int NODE = gy * N_X + gx;

            hermes_router #(
                .ROUTER_X  (gx       ),
                .ROUTER_Y  (gy       ),
                .BUF_DEPTH (BUF_DEPTH)
            ) u_router (
                .clk_i    (clk_i          ),
                .rst_n_i  (rst_n_i        ),
                .rx_i     (rx[NODE]       ),
                .eop_i    (eop_rx[NODE]   ),
                .data_i   (data_rx[NODE]  ),
                .credit_o (credit_rx[NODE]),
                .tx_o     (tx[NODE]       ),
                .eop_o    (eop_tx[NODE]   ),
                .data_o   (data_tx[NODE]  ),
                .credit_i (credit_tx[NODE])
            );

            // XY routing never aims a packet off the edge of the mesh.
            if (gx == N_X - 1) begin : gen_chk_east
                a_border_east: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    !tx[NODE][mesh_pkg::PORT_EAST]);
            end
            if (gx == 0) begin : gen_chk_west
                a_border_west: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    !tx[NODE][mesh_pkg::PORT_WEST]);
            end
            if (gy == N_Y - 1) begin : gen_chk_north
                a_border_north: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    !tx[NODE][mesh_pkg::PORT_NORTH]);
            end
            if (gy == 0) begin : gen_chk_south
                a_border_south: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    !tx[NODE][mesh_pkg::PORT_SOUTH]);
            end
        end
    end

    // Neighbour links cross tx to rx and credit back.
    // Border ports see an idle link that always has room.
    always_comb begin
        int n;
        for (int y = 0; y < N_Y; y++) begin
            for (int x = 0; x < N_X; x++) begin
                n = y * N_X + x;

                if (x != N_X - 1) begin
                    rx[n][mesh_pkg::PORT_EAST]        = tx[n + 1][mesh_pkg::PORT_WEST];
                    eop_rx[n][mesh_pkg::PORT_EAST]    = eop_tx[n + 1][mesh_pkg::PORT_WEST];
                    data_rx[n][mesh_pkg::PORT_EAST]   = data_tx[n + 1][mesh_pkg::PORT_WEST];
                    credit_tx[n][mesh_pkg::PORT_EAST] = credit_rx[n + 1][mesh_pkg::PORT_WEST];
                end else begin
                    rx[n][mesh_pkg::PORT_EAST]        = 1'b0;
                    eop_rx[n][mesh_pkg::PORT_EAST]    = 1'b0;
                    data_rx[n][mesh_pkg::PORT_EAST]   = '0;
                    credit_tx[n][mesh_pkg::PORT_EAST] = 1'b1;
                end

                if (x != 0) begin
                    rx[n][mesh_pkg::PORT_WEST]        = tx[n - 1][mesh_pkg::PORT_EAST];
                    eop_rx[n][mesh_pkg::PORT_WEST]    = eop_tx[n - 1][mesh_pkg::PORT_EAST];
                    data_rx[n][mesh_pkg::PORT_WEST]   = data_tx[n - 1][mesh_pkg::PORT_EAST];
                    credit_tx[n][mesh_pkg::PORT_WEST] = credit_rx[n - 1][mesh_pkg::PORT_EAST];
                end else begin
                    rx[n][mesh_pkg::PORT_WEST]        = 1'b0;
                    eop_rx[n][mesh_pkg::PORT_WEST]    = 1'b0;
                    data_rx[n][mesh_pkg::PORT_WEST]   = '0;
                    credit_tx[n][mesh_pkg::PORT_WEST] = 1'b1;
                end

                if (y != N_Y - 1) begin
                    rx[n][mesh_pkg::PORT_NORTH]        = tx[n + N_X][mesh_pkg::PORT_SOUTH];
                    eop_rx[n][mesh_pkg::PORT_NORTH]    = eop_tx[n + N_X][mesh_pkg::PORT_SOUTH];
                    data_rx[n][mesh_pkg::PORT_NORTH]   = data_tx[n + N_X][mesh_pkg::PORT_SOUTH];
                    credit_tx[n][mesh_pkg::PORT_NORTH] = credit_rx[n + N_X][mesh_pkg::PORT_SOUTH];
                end else begin
                    rx[n][mesh_pkg::PORT_NORTH]        = 1'b0;
                    eop_rx[n][mesh_pkg::PORT_NORTH]    = 1'b0;
                    data_rx[n][mesh_pkg::PORT_NORTH]   = '0;
                    credit_tx[n][mesh_pkg::PORT_NORTH] = 1'b1;
                end

                if (y != 0) begin
                    rx[n][mesh_pkg::PORT_SOUTH]        = tx[n - N_X][mesh_pkg::PORT_NORTH];
                    eop_rx[n][mesh_pkg::PORT_SOUTH]    = eop_tx[n - N_X][mesh_pkg::PORT_NORTH];
                    data_rx[n][mesh_pkg::PORT_SOUTH]   = data_tx[n - N_X][mesh_pkg::PORT_NORTH];
                    credit_tx[n][mesh_pkg::PORT_SOUTH] = credit_rx[n - N_X][mesh_pkg::PORT_NORTH];
                end else begin
                    rx[n][mesh_pkg::PORT_SOUTH]        = 1'b0;
                    eop_rx[n][mesh_pkg::PORT_SOUTH]    = 1'b0;
                    data_rx[n][mesh_pkg::PORT_SOUTH]   = '0;
                    credit_tx[n][mesh_pkg::PORT_SOUTH] = 1'b1;
                end

                // Local port goes straight to the top level
                rx[n][mesh_pkg::PORT_LOCAL]        = local_rx_i[n];
                eop_rx[n][mesh_pkg::PORT_LOCAL]    = local_eop_i[n];
                data_rx[n][mesh_pkg::PORT_LOCAL]   = local_data_i[n];
                credit_tx[n][mesh_pkg::PORT_LOCAL] = local_credit_i[n];
                local_credit_o[n]                  = credit_rx[n][mesh_pkg::PORT_LOCAL];
                local_tx_o[n]                      = tx[n][mesh_pkg::PORT_LOCAL];
                local_eop_o[n]                     = eop_tx[n][mesh_pkg::PORT_LOCAL];
                local_data_o[n]                    = data_tx[n][mesh_pkg::PORT_LOCAL];
            end
        end
    end

endmodule

// ==== verification/tb_noc_checks.svh ====
`ifndef TB_NOC_CHECKS_SVH
`define TB_NOC_CHECKS_SVH

// Expected traffic, one queue per source and destination node.
mesh_pkg::flit_t exp_flit_q [N_NODES][N_NODES][$];
int              exp_len_q  [N_NODES][N_NODES][$];

int    err_count   = 0;
int    pending     = 0;
int    flits_total = 0;
int    seq_cnt     = 0;
string cur_test    = "none";

function automatic mesh_pkg::node_addr_t addr_of(int node);
    return {8'(node % N_X), 8'(node / N_X)};
endfunction

function automatic int node_of(mesh_pkg::node_addr_t addr);
    return int'(addr[7:0]) * N_X + int'(addr[15:8]);
endfunction

// Walks the XY rule hop by hop from the source router.
function automatic int ref_dest_node(int src, mesh_pkg::node_addr_t dst,
                                     output mesh_pkg::port_e exit_port);
    mesh_pkg::node_addr_t cur;
    cur       = addr_of(src);
    exit_port = mesh_pkg::PORT_EAST;
    for (int hop = 0; hop <= N_X + N_Y; hop++) begin
        if (dst[15:8] > cur[15:8]) begin
            cur[15:8] = cur[15:8] + 8'd1;
        end else if (dst[15:8] < cur[15:8]) begin
            cur[15:8] = cur[15:8] - 8'd1;
        end else if (dst[7:0] > cur[7:0]) begin
            cur[7:0] = cur[7:0] + 8'd1;
        end else if (dst[7:0] < cur[7:0]) begin
            cur[7:0] = cur[7:0] - 8'd1;
        end else begin
            exit_port = mesh_pkg::PORT_LOCAL;
            return node_of(cur);
        end
    end
    return -1;
endfunction

// Header first, then payload flits of source address and sequence number.
task automatic build_packet(int src, int dst, int n_payload);
    mesh_pkg::flit_t f;
    mesh_pkg::port_e exit_port;
    int              d_node;
    d_node = ref_dest_node(src, addr_of(dst), exit_port);
    f = '0;
    f[mesh_pkg::HDR_SRC_LSB +: 16]  = addr_of(src);
    f[mesh_pkg::HDR_DEST_LSB +: 16] = addr_of(dst);
    for (int i = 0; i <= n_payload; i++) begin
        if (i > 0) begin
            f = {addr_of(src), 16'(seq_cnt)};
            seq_cnt++;
        end
        tx_flit_q[src].push_back(f);
        tx_eop_q[src].push_back(i == n_payload);
        exp_flit_q[src][d_node].push_back(f);
    end
    exp_len_q[src][d_node].push_back(n_payload + 1);
    flits_total += n_payload + 1;
    pending++;
endtask

task automatic check_flit(string what, mesh_pkg::flit_t exp, mesh_pkg::flit_t act);
    if (exp !== act) begin
        err_count++;
        $display("FAIL %s %s: expected %08h actual %08h", cur_test, what, exp, act);
    end
endtask

task automatic check_node(string what, mesh_pkg::node_addr_t exp, mesh_pkg::node_addr_t act);
    if (exp !== act) begin
        err_count++;
        $display("FAIL %s %s: expected %04h actual %04h", cur_test, what, exp, act);
    end
endtask

task automatic check_count(string what, int exp, int act);
    if (exp != act) begin
        err_count++;
        $display("FAIL %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    end
endtask

`endif

// ==== verification/tb_noc_mesh.sv ====
`timescale 1ns/1ps

module tb_noc_mesh;

    localparam int N_X       = 2;
    localparam int N_Y       = 2;
    localparam int N_NODES   = N_X * N_Y;
    localparam int BUF_DEPTH = 4;

    logic                 clk;
    logic                 rst_n;
    logic [N_NODES-1:0]   local_rx;
    logic [N_NODES-1:0]   local_eop;
    mesh_pkg::flit_t      local_data [N_NODES];
    logic [N_NODES-1:0]   local_credit_o;
    logic [N_NODES-1:0]   local_tx_o;
    logic [N_NODES-1:0]   local_eop_o;
    mesh_pkg::flit_t      local_data_o [N_NODES];
    logic [N_NODES-1:0]   local_credit;

    // Driver queues and finished packets from the monitors.
    mesh_pkg::flit_t tx_flit_q   [N_NODES][$];
    logic            tx_eop_q    [N_NODES][$];
    mesh_pkg::flit_t rx_pkt_q    [N_NODES][$];
    int              rx_flit_cnt [N_NODES];
    mesh_pkg::flit_t fin_flit_q  [$];
    int              fin_node_q  [$];
    int              fin_len_q   [$];

    integer seed = 32'h2f8e;
    int     tests_run      = 0;
    int     tests_failed   = 0;
    int     test_err_start = 0;
    int     cycles;
    int     base;

    `include "tb_noc_checks.svh"

    noc_mesh #(
        .N_X       (N_X      ),
        .N_Y       (N_Y      ),
        .BUF_DEPTH (BUF_DEPTH)
    ) dut_i (
        .clk_i          (clk           ),
        .rst_n_i        (rst_n         ),
        .local_rx_i     (local_rx      ),
        .local_eop_i    (local_eop     ),
        .local_data_i   (local_data    ),
        .local_credit_o (local_credit_o),
        .local_tx_o     (local_tx_o    ),
        .local_eop_o    (local_eop_o   ),
        .local_data_o   (local_data_o  ),
        .local_credit_i (local_credit  )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    for (genvar g = 0; g < N_NODES; g++) begin : gen_port
        // A flit is gone once rx and credit were both high at the edge.
        initial begin
            forever begin
                @(posedge clk);
                if (rst_n && local_rx[g] && local_credit_o[g]) begin
                    void'(tx_flit_q[g].pop_front());
                    void'(tx_eop_q[g].pop_front());
                end
                #2;
                if (tx_flit_q[g].size() != 0) begin
                    local_rx[g]   = 1'b1;
                    local_eop[g]  = tx_eop_q[g][0];
                    local_data[g] = tx_flit_q[g][0];
                end else begin
                    local_rx[g]  = 1'b0;
                    local_eop[g] = 1'b0;
                end
            end
        end

        initial begin
            forever begin
                @(posedge clk);
                if (rst_n && local_tx_o[g] && local_credit[g]) begin
                    rx_pkt_q[g].push_back(local_data_o[g]);
                    rx_flit_cnt[g]++;
                    if (local_eop_o[g]) begin
                        fin_node_q.push_back(g);
                        fin_len_q.push_back(rx_pkt_q[g].size());
                        while (rx_pkt_q[g].size() != 0) begin
                            fin_flit_q.push_back(rx_pkt_q[g].pop_front());
                        end
                    end
                end
            end
        end
    end

    task automatic compare_packet();
        int                   d;
        int                   len;
        int                   s;
        int                   exp_len;
        int                   ref_node;
        mesh_pkg::flit_t      got [$];
        mesh_pkg::flit_t      hdr;
        mesh_pkg::flit_t      exp_f;
        mesh_pkg::port_e      exit_port;
        mesh_pkg::node_addr_t src_addr;
        d   = fin_node_q.pop_front();
        len = fin_len_q.pop_front();
        for (int i = 0; i < len; i++) begin
            got.push_back(fin_flit_q.pop_front());
        end
        hdr      = got[0];
        src_addr = hdr[mesh_pkg::HDR_SRC_LSB +: 16];
        s        = node_of(src_addr);
        ref_node = ref_dest_node(s, hdr[mesh_pkg::HDR_DEST_LSB +: 16], exit_port);
        check_count("arrival node", ref_node, d);
        check_count("exit port", int'(mesh_pkg::PORT_LOCAL), int'(exit_port));
        // Wormhole: every body flit belongs to the header's source.
        for (int i = 1; i < len; i++) begin
            check_node("payload source", src_addr, got[i][31:16]);
        end
        if (s >= N_NODES || exp_len_q[s][d].size() == 0) begin
            err_count++;
            $display("Test %s: node %0d got a packet from %04h that was never sent there",
                     cur_test, d, src_addr);
            return;
        end
        exp_len = exp_len_q[s][d].pop_front();
        check_count("packet length", exp_len, len);
        for (int i = 0; i < exp_len; i++) begin
            exp_f = exp_flit_q[s][d].pop_front();
            if (i < len) begin
                check_flit($sformatf("flit %0d", i), exp_f, got[i]);
            end
        end
        pending--;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            while (fin_len_q.size() != 0) begin
                compare_packet();
            end
        end
    end

    // Limit grows with the traffic queued so far.
    initial begin
        cycles = 0;
        while (cycles <= 200 * flits_total + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog: traffic still pending after %0d cycles in %s", cycles, cur_test);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic start_test(string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_err_start) begin
            $display("Test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: %0d error(s)", cur_test, err_count - test_err_start);
        end
    endtask

    task automatic wait_drain();
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        local_rx     = '0;
        local_eop    = '0;
        local_credit = '1;
        for (int n = 0; n < N_NODES; n++) begin
            local_data[n] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_count("local_tx_o", 0, int'(local_tx_o));
        check_count("local_credit_o", (1 << N_NODES) - 1, int'(local_credit_o));
        end_test();

        start_test("single_0_to_3");
        @(negedge clk);
        build_packet(0, 3, 5);
        wait_drain();
        check_count("flits at node 3", 6, rx_flit_cnt[3]);
        check_count("flits elsewhere", 0, rx_flit_cnt[0] + rx_flit_cnt[1] + rx_flit_cnt[2]);
        end_test();

        start_test("self_loop");
        @(negedge clk);
        build_packet(2, 2, 3);
        wait_drain();
        end_test();

        start_test("all_to_all");
        @(negedge clk);
        for (int n = 0; n < N_NODES; n++) begin
            for (int k = 0; k < 4; k++) begin
                build_packet(n, $unsigned($random(seed)) % N_NODES,
                             1 + $unsigned($random(seed)) % 6);
            end
        end
        wait_drain();
        end_test();

        start_test("backpressure");
        base = rx_flit_cnt[3];
        @(negedge clk);
        for (int n = 0; n < 3; n++) begin
            build_packet(n, 3, 6);
        end
        @(posedge clk);
        #2;
        local_credit[3] = 1'b0;
        repeat (50) @(posedge clk);
        #2;
        local_credit[3] = 1'b1;
        wait_drain();
        check_count("flits at node 3", base + 21, rx_flit_cnt[3]);
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verification
logic/mesh_pkg.sv
logic/input_buffer.sv
logic/output_arbiter.sv
logic/hermes_router.sv
logic/noc_mesh.sv
verification/tb_noc_mesh.sv
